//--- common/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operation codes 0 to 25
`define OP_ADD      5'd0
`define OP_SUB      5'd1
`define OP_MULT     5'd2
`define OP_MULTU    5'd3
`define OP_DIV      5'd4
`define OP_DIVU     5'd5
`define OP_AND      5'd6
`define OP_OR       5'd7
`define OP_XOR      5'd8
`define OP_SLL      5'd9
`define OP_SLLV     5'd10
`define OP_SRL      5'd11
`define OP_SRLV     5'd12
`define OP_SRA      5'd13
`define OP_SRAV     5'd14
`define OP_EQ       5'd15
`define OP_GEZ      5'd16
`define OP_GTZ      5'd17
`define OP_LEZ      5'd18
`define OP_LTZ      5'd19
`define OP_SLT      5'd20
`define OP_SLTU     5'd21
`define OP_NE       5'd22
`define OP_PASS     5'd23
`define OP_JMP      5'd24
`define OP_LUI      5'd25

// word registers indexed by bus address bits 4 to 2
`define REG_RS      3'd0
`define REG_RT      3'd1
`define REG_SHAMT   3'd2
`define REG_CTRL    3'd3
`define REG_OUT     3'd4
`define REG_LO      3'd5
`define REG_HI      3'd6
`define REG_STATUS  3'd7

`define DIV_STEPS   32

`endif

//--- common/alu_pkg.sv
package alu_pkg;

    // data word for operands and bus data
    typedef logic [31:0] word_t;

    // multiply product or HI:LO pair
    typedef logic [63:0] dword_t;

    typedef logic [4:0] shamt_t;

    typedef logic [4:0] op_t;

    // word index from adr[4:2]
    typedef logic [2:0] reg_addr_t;

    // divider iteration count up to DIV_STEPS
    typedef logic [5:0] step_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_DIV_RUN,
        ST_DIV_ACK
    } ctrl_state_t;

endpackage

//--- alu/alu.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu (
    input  alu_pkg::word_t  rs,
    input  alu_pkg::word_t  rt,
    input  alu_pkg::shamt_t shamt,
    input  alu_pkg::op_t    op,
    output alu_pkg::word_t  result,
    output alu_pkg::dword_t product,
    output logic            bflag
);

    alu_pkg::shamt_t var_shamt;
    alu_pkg::dword_t prod_s;
    alu_pkg::dword_t prod_u;
    logic            is_cmp;

    assign var_shamt = rt[4:0]; // variable shifts take rt[4:0]

    // signed or unsigned product picked by code
    assign prod_s = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
    assign prod_u = {32'd0, rs} * {32'd0, rt};
    assign product = (op == `OP_MULT) ? prod_s : prod_u;

    always_comb begin
        case (op)
            `OP_ADD: begin
                result = rs + rt;
            end
            `OP_SUB: begin
                result = rs - rt;
            end
            `OP_AND: begin
                result = rs & rt;
            end
            `OP_OR: begin
                result = rs | rt;
            end
            `OP_XOR: begin
                result = rs ^ rt;
            end
            `OP_SLL: begin
                result = rs << shamt;
            end
            `OP_SLLV: begin
                result = rs << var_shamt;
            end
            `OP_SRL: begin
                result = rs >> shamt;
            end
            `OP_SRLV: begin
                result = rs >> var_shamt;
            end
            `OP_SRA: begin
                result = $signed(rs) >>> shamt;
            end
            `OP_SRAV: begin
                result = $signed(rs) >>> var_shamt;
            end
            `OP_EQ: begin
                result = {31'd0, rs == rt};
            end
            `OP_GEZ: begin
                result = {31'd0, ~rs[31]}; // sign bit clear
            end
            `OP_GTZ: begin
                result = {31'd0, ~rs[31] && (rs != '0)};
            end
            `OP_LEZ: begin
                result = {31'd0, rs[31] || (rs == '0)};
            end
            `OP_LTZ: begin
                result = {31'd0, rs[31]};
            end
            `OP_SLT: begin
                result = {31'd0, $signed(rs) < $signed(rt)};
            end
            `OP_SLTU: begin
                result = {31'd0, rs < rt};
            end
            `OP_NE: begin
                result = {31'd0, rs != rt};
            end
            `OP_PASS: begin
                result = rs;
            end
            `OP_JMP: begin
                result = 32'd1; // jump marker
            end
            `OP_LUI: begin
                result = rt << 16;
            end
            default: begin
                result = '0; // mult/div and unused codes 26..31
            end
        endcase
    end

    assign is_cmp = (op >= `OP_EQ) && (op <= `OP_NE);
    assign bflag  = is_cmp ? result[0] : 1'b0; // only compare codes branch

endmodule

//--- alu/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           step,
    input  logic           signed_mode,
    input  alu_pkg::word_t dividend,
    input  alu_pkg::word_t divisor,
    output alu_pkg::word_t quotient,
    output alu_pkg::word_t remainder
);

    alu_pkg::word_t rem_q;
    alu_pkg::word_t quo_q;
    alu_pkg::word_t dvs_q;      // divisor magnitude
    alu_pkg::word_t rs_q;       // raw dividend for the zero-divisor case
    logic           q_neg_q;
    logic           r_neg_q;
    logic           dz_q;

    alu_pkg::word_t dvd_mag;
    alu_pkg::word_t dvs_mag;
    logic [32:0]    rem_shift;
    logic [32:0]    diff;

    assign dvd_mag = (signed_mode && dividend[31]) ? -dividend : dividend;
    assign dvs_mag = (signed_mode && divisor[31]) ? -divisor : divisor;

    // restoring step brings in the next dividend bit and tries a subtract
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_neg_q <= 1'b0;
            r_neg_q <= 1'b0;
            dz_q    <= 1'b0;
        end else if (start) begin
            q_neg_q <= signed_mode && (dividend[31] ^ divisor[31]);
            r_neg_q <= signed_mode && dividend[31]; // remainder follows dividend
            dz_q    <= (divisor == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= dvd_mag;
            dvs_q <= dvs_mag;
            rs_q  <= dividend;
        end else if (step) begin
            if (!diff[32]) begin
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= rem_shift[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    assign quotient  = dz_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign remainder = dz_q ? rs_q : (r_neg_q ? -rem_q : rem_q);

endmodule

//--- logic/step_counter.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module step_counter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clear,
    input  logic           run,
    output alu_pkg::step_t count,
    output logic           last_step
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0; // clear wins over run
        end else if (run) begin
            count <= count + 1'b1;
        end
    end

    // high on the final iteration only
    assign last_step = run && !clear &&
                       (count == alu_pkg::step_t'(`DIV_STEPS - 1));

endmodule

//--- logic/exec_ctrl.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module exec_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  alu_pkg::reg_addr_t adr,
    input  alu_pkg::op_t       op_w,
    input  logic               last_step,
    output logic               ack,
    output logic               reg_we,
    output logic               cap_alu,
    output logic               div_start,
    output logic               cap_div,
    output logic               busy
);

    alu_pkg::ctrl_state_t state;
    alu_pkg::ctrl_state_t state_nxt;

    logic req;
    logic ctrl_wr;
    logic is_div;
    logic alu_pend_q;               // CTRL write waiting for result capture

    assign req     = cyc && stb && (state == alu_pkg::ST_IDLE);
    assign ctrl_wr = req && we && (adr == `REG_CTRL);
    assign is_div  = (op_w == `OP_DIV) || (op_w == `OP_DIVU);

    always_comb begin
        state_nxt = state;
        case (state)
            alu_pkg::ST_IDLE: begin
                if (req) begin
                    state_nxt = (ctrl_wr && is_div) ? alu_pkg::ST_DIV_RUN : alu_pkg::ST_ACK;
                end
            end
            alu_pkg::ST_ACK: begin
                state_nxt = alu_pkg::ST_IDLE;
            end
            alu_pkg::ST_DIV_RUN: begin
                if (last_step) begin
                    state_nxt = alu_pkg::ST_DIV_ACK;
                end
            end
            default: begin
                state_nxt = alu_pkg::ST_IDLE; // ST_DIV_ACK
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= alu_pkg::ST_IDLE;
            alu_pend_q <= 1'b0;
            div_start  <= 1'b0;
        end else begin
            state      <= state_nxt;
            alu_pend_q <= ctrl_wr && !is_div;
            div_start  <= ctrl_wr && is_div; // pulse after the op register is loaded
        end
    end

    assign reg_we  = req && we; // registers written on the request edge
    assign ack     = (state == alu_pkg::ST_ACK) || (state == alu_pkg::ST_DIV_ACK);
    assign cap_alu = (state == alu_pkg::ST_ACK) && alu_pend_q;
    assign cap_div = (state == alu_pkg::ST_DIV_ACK);
    assign busy    = (state == alu_pkg::ST_DIV_RUN);

endmodule

//--- logic/wb_regs.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module wb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_we,
    input  logic               cap_alu,
    input  logic               cap_div,
    input  logic               busy,
    input  alu_pkg::reg_addr_t adr,
    input  alu_pkg::word_t     dat_w,
    input  alu_pkg::word_t     alu_result,
    input  alu_pkg::dword_t    alu_product,
    input  logic               alu_bflag,
    input  alu_pkg::word_t     quotient,
    input  alu_pkg::word_t     remainder,
    output alu_pkg::word_t     dat_r,
    output alu_pkg::word_t     rs,
    output alu_pkg::word_t     rt,
    output alu_pkg::shamt_t    shamt,
    output alu_pkg::op_t       op
);

    alu_pkg::word_t out_q;
    alu_pkg::word_t lo_q;
    alu_pkg::word_t hi_q;
    logic           flag_q;
    logic           is_mul;

    assign is_mul = (op == `OP_MULT) || (op == `OP_MULTU);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs     <= '0;
            rt     <= '0;
            shamt  <= '0;
            op     <= '0;
            out_q  <= '0;
            lo_q   <= '0;
            hi_q   <= '0;
            flag_q <= 1'b0;
        end else begin
            if (reg_we) begin
                case (adr)
                    `REG_RS:    rs    <= dat_w;
                    `REG_RT:    rt    <= dat_w;
                    `REG_SHAMT: shamt <= dat_w[4:0];
                    `REG_CTRL:  op    <= dat_w[4:0];
                    default: ; // result registers are read only
                endcase
            end
            if (cap_alu) begin
                out_q  <= alu_result;
                flag_q <= alu_bflag;
                if (is_mul) begin
                    hi_q <= alu_product[63:32];
                    lo_q <= alu_product[31:0];
                end
            end
            if (cap_div) begin
                out_q  <= '0; // divide has no OUT word and never branches
                flag_q <= 1'b0;
                lo_q   <= quotient;
                hi_q   <= remainder;
            end
        end
    end

    always_comb begin
        case (adr)
            `REG_RS:    dat_r = rs;
            `REG_RT:    dat_r = rt;
            `REG_SHAMT: dat_r = {27'd0, shamt};
            `REG_CTRL:  dat_r = {27'd0, op};
            `REG_OUT:   dat_r = out_q;
            `REG_LO:    dat_r = lo_q;
            `REG_HI:    dat_r = hi_q;
            default:    dat_r = {30'd0, busy, flag_q}; // STATUS
        endcase
    end

endmodule

//--- logic/alu_top.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  alu_pkg::reg_addr_t adr,
    input  alu_pkg::word_t     dat_w,
    output alu_pkg::word_t     dat_r,
    output logic               ack
);

    logic            reg_we;
    logic            cap_alu;
    logic            cap_div;
    logic            div_start;
    logic            busy;
    logic            last_step;
    alu_pkg::word_t  rs;
    alu_pkg::word_t  rt;
    alu_pkg::shamt_t shamt;
    alu_pkg::op_t    op;
    alu_pkg::word_t  alu_result;
    alu_pkg::dword_t alu_product;
    logic            alu_bflag;
    alu_pkg::word_t  quotient;
    alu_pkg::word_t  remainder;

    exec_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .op_w(dat_w[4:0]), .last_step(last_step), .ack(ack), .reg_we(reg_we),
        .cap_alu(cap_alu), .div_start(div_start), .cap_div(cap_div), .busy(busy)
    );

    step_counter u_steps (
        .clk(clk), .rst_n(rst_n), .clear(div_start), .run(busy),
        .count(), .last_step(last_step)
    );

    div_unit u_div (
        .clk(clk), .rst_n(rst_n), .start(div_start), .step(busy),
        .signed_mode(op == `OP_DIV), .dividend(rs), .divisor(rt),
        .quotient(quotient), .remainder(remainder)
    );

    alu u_alu (
        .rs(rs), .rt(rt), .shamt(shamt), .op(op),
        .result(alu_result), .product(alu_product), .bflag(alu_bflag)
    );

    wb_regs u_regs (
        .clk(clk), .rst_n(rst_n), .reg_we(reg_we), .cap_alu(cap_alu),
        .cap_div(cap_div), .busy(busy), .adr(adr), .dat_w(dat_w),
        .alu_result(alu_result), .alu_product(alu_product), .alu_bflag(alu_bflag),
        .quotient(quotient), .remainder(remainder), .dat_r(dat_r),
        .rs(rs), .rt(rt), .shamt(shamt), .op(op)
    );

endmodule

//--- dv/alu_tb.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_tb;

    localparam int N_RAND = 4; // random operand sets per code
    localparam int N_OPS  = 8 + 2 * (3 + N_RAND) + 2 * (4 + N_RAND) + 20 * N_RAND
                            + 8 * (6 + N_RAND);
    localparam int WATCHDOG_CYCLES = N_OPS * 40 + 500;

    logic               clk;
    logic               rst_n;
    logic               cyc;
    logic               stb;
    logic               we;
    alu_pkg::reg_addr_t adr;
    alu_pkg::word_t     dat_w;
    alu_pkg::word_t     dat_r;
    logic               ack;

    logic [31:0]     lfsr = 32'd84;
    int              n_errors = 0;
    int              n_checks = 0;
    int              n_issued = 0;
    int              n_done = 0;
    event            obs_ev;
    alu_pkg::word_t  q_rs[$];
    alu_pkg::word_t  q_rt[$];
    alu_pkg::shamt_t q_sh[$];
    alu_pkg::op_t    q_op[$];
    alu_pkg::word_t  q_out[$];
    alu_pkg::word_t  q_lo[$];
    alu_pkg::word_t  q_hi[$];
    alu_pkg::word_t  q_st[$];
    alu_pkg::word_t  f_rs[6];   // forced compare operands
    alu_pkg::word_t  f_rt[6];

    alu_top dut0 (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
    endfunction

    function automatic alu_pkg::word_t rand_bits(input int n);
        alu_pkg::word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    // expected OUT, HI, LO and flag for one operation
    function automatic void alu_ref(
        input  alu_pkg::word_t  a,
        input  alu_pkg::word_t  b,
        input  alu_pkg::shamt_t sh,
        input  alu_pkg::op_t    op,
        input  alu_pkg::word_t  hi_in,
        input  alu_pkg::word_t  lo_in,
        output alu_pkg::word_t  res,
        output alu_pkg::word_t  hi,
        output alu_pkg::word_t  lo,
        output logic            flag
    );
        longint      sa;
        longint      sb;
        longint      sq;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        res = '0;
        hi = hi_in;
        lo = lo_in;
        case (op)
            `OP_ADD:   res = a + b;
            `OP_SUB:   res = a - b;
            `OP_AND:   res = a & b;
            `OP_OR:    res = a | b;
            `OP_XOR:   res = a ^ b;
            `OP_SLL:   res = a << sh;
            `OP_SLLV:  res = a << b[4:0];
            `OP_SRL:   res = a >> sh;
            `OP_SRLV:  res = a >> b[4:0];
            `OP_SRA: begin
                sq  = sa >>> sh;
                res = sq[31:0];
            end
            `OP_SRAV: begin
                sq  = sa >>> b[4:0];
                res = sq[31:0];
            end
            `OP_EQ:    res = (a == b) ? 32'd1 : 32'd0;
            `OP_GEZ:   res = (sa >= 0) ? 32'd1 : 32'd0;
            `OP_GTZ:   res = (sa > 0) ? 32'd1 : 32'd0;
            `OP_LEZ:   res = (sa <= 0) ? 32'd1 : 32'd0;
            `OP_LTZ:   res = (sa < 0) ? 32'd1 : 32'd0;
            `OP_SLT:   res = (sa < sb) ? 32'd1 : 32'd0;
            `OP_SLTU:  res = (ua < ub) ? 32'd1 : 32'd0;
            `OP_NE:    res = (a != b) ? 32'd1 : 32'd0;
            `OP_PASS:  res = a;
            `OP_JMP:   res = 32'd1;
            `OP_LUI:   res = {b[15:0], 16'd0};
            `OP_MULT: begin
                p  = sa * sb;
                hi = p[63:32];
                lo = p[31:0];
            end
            `OP_MULTU: begin
                p  = ua * ub;
                hi = p[63:32];
                lo = p[31:0];
            end
            `OP_DIV, `OP_DIVU: begin
                if (b == '0) begin
                    lo = '1; // zero divisor rule
                    hi = a;
                end else if (op == `OP_DIV) begin
                    sq = sa / sb; // truncates toward zero
                    lo = sq[31:0];
                    sq = sa % sb;
                    hi = sq[31:0];
                end else begin
                    p = ua / ub;
                    lo = p[31:0];
                    p = ua % ub;
                    hi = p[31:0];
                end
            end
            default:   res = '0;
        endcase
        flag = (op >= `OP_EQ && op <= `OP_NE) ? res[0] : 1'b0;
    endfunction

    task automatic check_word(input string what, input alu_pkg::word_t got,
                              input alu_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_for_ack();
        @(negedge clk);
        while (!ack) @(negedge clk);
    endtask

    task automatic wb_write(input alu_pkg::reg_addr_t a, input alu_pkg::word_t d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        wait_for_ack();
        @(posedge clk);
        cyc <= 1'b0; // drop in the cycle after ack
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        check_flag("ack low after write", ack, 1'b0);
    endtask

    task automatic wb_read(input alu_pkg::reg_addr_t a, output alu_pkg::word_t d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        wait_for_ack();
        d = dat_r; // sampled mid cycle while ack is high
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        @(negedge clk);
        check_flag("ack low after read", ack, 1'b0);
    endtask

    task automatic exec_op(input alu_pkg::word_t a, input alu_pkg::word_t b,
                           input alu_pkg::shamt_t sh, input alu_pkg::op_t op);
        alu_pkg::word_t rd;
        wb_write(`REG_RS, a);
        wb_write(`REG_RT, b);
        wb_write(`REG_SHAMT, {27'd0, sh});
        wb_write(`REG_CTRL, {27'd0, op}); // starts the operation
        q_rs.push_back(a);
        q_rt.push_back(b);
        q_sh.push_back(sh);
        q_op.push_back(op);
        wb_read(`REG_OUT, rd);
        q_out.push_back(rd);
        wb_read(`REG_LO, rd);
        q_lo.push_back(rd);
        wb_read(`REG_HI, rd);
        q_hi.push_back(rd);
        wb_read(`REG_STATUS, rd);
        q_st.push_back(rd);
        n_issued++;
        -> obs_ev;
    endtask

    // compares each finished operation against the reference
    initial begin : compare_proc
        alu_pkg::word_t  c_rs;
        alu_pkg::word_t  c_rt;
        alu_pkg::shamt_t c_sh;
        alu_pkg::op_t    c_op;
        alu_pkg::word_t  e_res;
        alu_pkg::word_t  e_hi;
        alu_pkg::word_t  e_lo;
        logic            e_flag;
        alu_pkg::word_t  g_st;
        alu_pkg::word_t  model_hi;
        alu_pkg::word_t  model_lo;
        model_hi = '0;
        model_lo = '0;
        forever begin
            @(obs_ev);
            while (q_op.size() > 0) begin
                c_rs = q_rs.pop_front();
                c_rt = q_rt.pop_front();
                c_sh = q_sh.pop_front();
                c_op = q_op.pop_front();
                g_st = q_st.pop_front();
                alu_ref(c_rs, c_rt, c_sh, c_op, model_hi, model_lo,
                        e_res, e_hi, e_lo, e_flag);
                check_word($sformatf("op %0d rs=%h rt=%h OUT", c_op, c_rs, c_rt),
                           q_out.pop_front(), e_res);
                check_word($sformatf("op %0d rs=%h rt=%h LO", c_op, c_rs, c_rt),
                           q_lo.pop_front(), e_lo);
                check_word($sformatf("op %0d rs=%h rt=%h HI", c_op, c_rs, c_rt),
                           q_hi.pop_front(), e_hi);
                check_flag($sformatf("op %0d branch flag", c_op), g_st[0], e_flag);
                check_flag($sformatf("op %0d busy bit", c_op), g_st[1], 1'b0);
                model_hi = e_hi;
                model_lo = e_lo;
                n_done++;
            end
        end
    end

    initial begin : stimulus
        alu_pkg::word_t rd;
        alu_pkg::word_t a_val;
        alu_pkg::word_t d_sign;
        alu_pkg::word_t d_low;
        int             c;
        int             k;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (k = 0; k < 8; k++) begin
            wb_read(alu_pkg::reg_addr_t'(k), rd);
            check_word($sformatf("reset value of register %0d", k), rd, '0);
        end
        // multiply and divide run first so later codes show HI/LO held
        for (c = `OP_MULT; c <= `OP_MULTU; c++) begin
            exec_op(32'hffff_ffff, 32'hffff_ffff, '0, alu_pkg::op_t'(c));
            exec_op(32'h8000_0000, 32'h8000_0000, '0, alu_pkg::op_t'(c));
            exec_op(32'hffff_fffb, 32'd7, '0, alu_pkg::op_t'(c));
            for (k = 0; k < N_RAND; k++) begin
                exec_op(rand_bits(32), rand_bits(32), '0, alu_pkg::op_t'(c));
            end
        end
        for (c = `OP_DIV; c <= `OP_DIVU; c++) begin
            exec_op(32'h8000_0000, 32'hffff_ffff, '0, alu_pkg::op_t'(c));
            exec_op(rand_bits(32) | 32'h8000_0000, 32'd0, '0, alu_pkg::op_t'(c));
            exec_op(32'hffff_fff9, 32'd2, '0, alu_pkg::op_t'(c));
            exec_op(32'd7, 32'hffff_fffe, '0, alu_pkg::op_t'(c));
            for (k = 0; k < N_RAND; k++) begin
                if (k[0]) begin
                    a_val  = rand_bits(32);
                    d_sign = rand_bits(1);
                    d_low  = rand_bits(8);
                    exec_op(a_val, {{24{d_sign[0]}}, d_low[7:0]}, '0,
                            alu_pkg::op_t'(c)); // small divisor
                end else begin
                    exec_op(rand_bits(32), rand_bits(32), '0, alu_pkg::op_t'(c));
                end
            end
        end
        f_rs[0] = rand_bits(32);
        f_rt[0] = f_rs[0];
        f_rs[1] = '0;
        f_rt[1] = '0;
        f_rs[2] = '0;
        f_rt[2] = rand_bits(32);
        f_rs[3] = 32'h7fff_ffff;
        f_rt[3] = 32'h8000_0000;
        f_rs[4] = 32'h8000_0000;
        f_rt[4] = 32'h7fff_ffff;
        f_rs[5] = 32'hffff_ffff;
        f_rt[5] = 32'd1;
        for (c = 0; c < 32; c++) begin
            if (c < `OP_MULT || c > `OP_DIVU) begin
                if (c >= `OP_EQ && c <= `OP_NE) begin
                    for (k = 0; k < 6; k++) begin
                        exec_op(f_rs[k], f_rt[k], '0, alu_pkg::op_t'(c));
                    end
                end
                for (k = 0; k < N_RAND; k++) begin
                    exec_op(rand_bits(32), rand_bits(32), alu_pkg::shamt_t'(rand_bits(5)),
                            alu_pkg::op_t'(c));
                end
            end
        end
        repeat (2) @(posedge clk);
        if (n_done != n_issued) begin
            n_errors++;
            $display("compare process finished %0d of %0d operations", n_done, n_issued);
        end
        $display("operations=%0d checks=%0d errors=%0d", n_issued, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the bus transfer never completed",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- src.f
+incdir+common
common/alu_pkg.sv
alu/alu.sv
alu/div_unit.sv
logic/step_counter.sv
logic/exec_ctrl.sv
logic/wb_regs.sv
logic/alu_top.sv
dv/alu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module alu_tb -o alu_sim

out=$(./obj_dir/alu_sim)
echo "$out"
echo "$out" | grep -qF "*** TEST PASSED ***"
